/* common/core_types_pkg.sv */
`default_nettype none

package core_types_pkg;

    //////////////////////////////
    // data path

    localparam int XLEN = 32;

    typedef logic [XLEN-1:0] word_t;
    typedef logic [31:0]     inst_t;

    // x0 .. x31
    typedef logic [4:0]      reg_addr_t;

    //////////////////////////////
    // instruction queue

    // also the credit count the source owns after reset
    localparam int QUEUE_DEPTH = 4;

    typedef logic [$clog2(QUEUE_DEPTH)-1:0]   queue_ptr_t;

    // count has to hold QUEUE_DEPTH itself
    typedef logic [$clog2(QUEUE_DEPTH+1)-1:0] queue_cnt_t;

endpackage

`default_nettype wire

/* common/isa_pkg.sv */
`default_nettype none

package isa_pkg;

    //////////////////////////////
    // rv32i encodings, subset only

    localparam logic [6:0] OPC_OP     = 7'b0110011;
    localparam logic [6:0] OPC_OP_IMM = 7'b0010011;
    localparam logic [6:0] OPC_LUI    = 7'b0110111;

    localparam logic [2:0] FUNCT3_ADD_SUB = 3'b000;
    localparam logic [2:0] FUNCT3_SLL     = 3'b001;
    localparam logic [2:0] FUNCT3_XOR     = 3'b100;
    localparam logic [2:0] FUNCT3_SRL     = 3'b101;
    localparam logic [2:0] FUNCT3_OR      = 3'b110;
    localparam logic [2:0] FUNCT3_AND     = 3'b111;

    // sub / sra marker
    localparam logic [6:0] FUNCT7_ALT = 7'b0100000;

    typedef enum logic [2:0] {
        ALU_ADD,
        ALU_SUB,
        ALU_AND,
        ALU_OR,
        ALU_XOR,
        ALU_SLL,
        ALU_SRL,
        ALU_PASS_B
    } alu_op_e;

    //////////////////////////////
    // stage payloads

    typedef struct packed {
        alu_op_e                   alu_op;
        logic                      use_imm;
        logic                      rf_wen;
        logic                      illegal;
        core_types_pkg::reg_addr_t rd;
        core_types_pkg::reg_addr_t rs1;
        core_types_pkg::reg_addr_t rs2;
        core_types_pkg::word_t     imm;
    } ctrl_t;

    // bypass entry, the wb one doubles as rf write port
    typedef struct packed {
        logic                      valid;
        core_types_pkg::reg_addr_t addr;
        core_types_pkg::word_t     wdata;
    } fwd_t;

    typedef struct packed {
        logic                      valid;
        logic                      wen;
        logic                      illegal;
        core_types_pkg::reg_addr_t rd;
        core_types_pkg::word_t     wdata;
    } retire_t;

endpackage

`default_nettype wire

/* hdl/inst_queue.sv */
`default_nettype none

module inst_queue (
    input  wire                     clk,
    input  wire                     rst_i,
    input  wire                     inst_valid_i,
    input  wire core_types_pkg::inst_t inst_i,
    output logic                    deq_valid_o,
    output core_types_pkg::inst_t   deq_inst_o,
    output logic                    credit_o
);

    import core_types_pkg::*;

    inst_t      mem [QUEUE_DEPTH];
    queue_ptr_t wr_ptr;
    queue_ptr_t rd_ptr;
    queue_cnt_t count;

    logic push;
    logic pop;

    assign push = inst_valid_i;

    // decode never stalls, drain whenever something is held
    assign pop = (count != '0);

    assign deq_valid_o = pop;
    assign deq_inst_o  = mem[rd_ptr];

    always_ff @(posedge clk) begin
        if (push) begin
            mem[wr_ptr] <= inst_i;
        end
    end

    always_ff @(posedge clk) begin
        if (rst_i) begin
            wr_ptr   <= '0;
            rd_ptr   <= '0;
            count    <= '0;
            credit_o <= 1'b0;
        end else begin
            if (push) begin
                wr_ptr <= wr_ptr + 1'b1;
            end
            if (pop) begin
                rd_ptr <= rd_ptr + 1'b1;
            end
            count    <= count + queue_cnt_t'(push) - queue_cnt_t'(pop);
            // one credit back per entry freed
            credit_o <= pop;
        end
    end

    // source must hold a credit to push
    assert property (@(posedge clk) disable iff (rst_i)
        inst_valid_i |-> (count < QUEUE_DEPTH));

    assert property (@(posedge clk) disable iff (rst_i)
        count <= QUEUE_DEPTH);

endmodule

`default_nettype wire

/* pipeline/decode_stage.sv */
`default_nettype none

module decode_stage (
    input  wire                        clk,
    input  wire                        rst_i,
    input  wire                        deq_valid_i,
    input  wire core_types_pkg::inst_t deq_inst_i,
    output logic                       id_valid_o,
    output isa_pkg::ctrl_t             id_ctrl_o
);

    import core_types_pkg::*;
    import isa_pkg::*;

    inst_t inst_q;

    logic [6:0] opcode;
    logic [2:0] funct3;
    logic [6:0] funct7;
    word_t      imm_i;
    word_t      imm_u;

    always_ff @(posedge clk) begin
        if (rst_i) begin
            id_valid_o <= 1'b0;
        end else begin
            id_valid_o <= deq_valid_i;
        end
    end

    always_ff @(posedge clk) begin
        inst_q <= deq_inst_i;
    end

    assign opcode = inst_q[6:0];
    assign funct3 = inst_q[14:12];
    assign funct7 = inst_q[31:25];

    assign imm_i = {{(XLEN-12){inst_q[31]}}, inst_q[31:20]};
    assign imm_u = {inst_q[31:12], 12'b0};

    always_comb begin
        id_ctrl_o         = '0;
        id_ctrl_o.alu_op  = ALU_ADD;
        id_ctrl_o.rd      = inst_q[11:7];
        id_ctrl_o.rs1     = inst_q[19:15];
        id_ctrl_o.rs2     = inst_q[24:20];

        case (opcode)
            OPC_OP: begin
                id_ctrl_o.rf_wen = 1'b1;
                case ({funct7, funct3})
                    {7'b0, FUNCT3_ADD_SUB}:     id_ctrl_o.alu_op = ALU_ADD;
                    {FUNCT7_ALT, FUNCT3_ADD_SUB}: id_ctrl_o.alu_op = ALU_SUB;
                    {7'b0, FUNCT3_SLL}:         id_ctrl_o.alu_op = ALU_SLL;
                    {7'b0, FUNCT3_SRL}:         id_ctrl_o.alu_op = ALU_SRL;
                    {7'b0, FUNCT3_XOR}:         id_ctrl_o.alu_op = ALU_XOR;
                    {7'b0, FUNCT3_OR}:          id_ctrl_o.alu_op = ALU_OR;
                    {7'b0, FUNCT3_AND}:         id_ctrl_o.alu_op = ALU_AND;
                    default:                    id_ctrl_o.illegal = 1'b1;
                endcase
            end
            OPC_OP_IMM: begin
                id_ctrl_o.rf_wen  = 1'b1;
                id_ctrl_o.use_imm = 1'b1;
                id_ctrl_o.imm     = imm_i;
                // shifts and compares by immediate are outside the subset
                case (funct3)
                    FUNCT3_ADD_SUB: id_ctrl_o.alu_op = ALU_ADD;
                    FUNCT3_XOR:     id_ctrl_o.alu_op = ALU_XOR;
                    FUNCT3_OR:      id_ctrl_o.alu_op = ALU_OR;
                    FUNCT3_AND:     id_ctrl_o.alu_op = ALU_AND;
                    default:        id_ctrl_o.illegal = 1'b1;
                endcase
            end
            OPC_LUI: begin
                id_ctrl_o.rf_wen  = 1'b1;
                id_ctrl_o.use_imm = 1'b1;
                id_ctrl_o.imm     = imm_u;
                id_ctrl_o.alu_op  = ALU_PASS_B;
            end
            default: begin
                id_ctrl_o.illegal = 1'b1;
            end
        endcase

        // no write for x0 or illegal encodings
        if (id_ctrl_o.illegal || id_ctrl_o.rd == '0) begin
            id_ctrl_o.rf_wen = 1'b0;
        end
    end

endmodule

`default_nettype wire

/* pipeline/operand_stage.sv */
`default_nettype none

module operand_stage (
    input  wire                  clk,
    input  wire                  rst_i,
    input  wire                  id_valid_i,
    input  wire isa_pkg::ctrl_t  id_ctrl_i,
    input  wire isa_pkg::fwd_t   exe_fwd_i,
    input  wire isa_pkg::fwd_t   wb_fwd_i,
    output logic                 op_valid_o,
    output isa_pkg::ctrl_t       op_ctrl_o,
    output core_types_pkg::word_t op_a_o,
    output core_types_pkg::word_t op_b_o
);

    import core_types_pkg::*;
    import isa_pkg::*;

    // x0 has no storage
    word_t rf [1:31];

    word_t rs1_rf;
    word_t rs2_rf;
    word_t rs1_val;
    word_t rs2_val;

    // newest producer wins
    function automatic word_t bypass(
        input reg_addr_t addr,
        input word_t     rf_val,
        input fwd_t      exe_f,
        input fwd_t      wb_f
    );
        word_t res;
        res = rf_val;
        if (addr != '0 && exe_f.valid && exe_f.addr == addr) begin
            res = exe_f.wdata;
        end else if (addr != '0 && wb_f.valid && wb_f.addr == addr) begin
            res = wb_f.wdata;
        end
        return res;
    endfunction

    ////////////////////////////////
    // register file

    always_ff @(posedge clk) begin
        if (wb_fwd_i.valid && wb_fwd_i.addr != '0) begin
            rf[wb_fwd_i.addr] <= wb_fwd_i.wdata;
        end
    end

    assign rs1_rf = (id_ctrl_i.rs1 == '0) ? '0 : rf[id_ctrl_i.rs1];
    assign rs2_rf = (id_ctrl_i.rs2 == '0) ? '0 : rf[id_ctrl_i.rs2];

    // wb entry is also this cycle's write, so it covers write-then-read
    assign rs1_val = bypass(id_ctrl_i.rs1, rs1_rf, exe_fwd_i, wb_fwd_i);
    assign rs2_val = bypass(id_ctrl_i.rs2, rs2_rf, exe_fwd_i, wb_fwd_i);

    ////////////////////////////////
    // operand register

    always_ff @(posedge clk) begin
        if (rst_i) begin
            op_valid_o <= 1'b0;
        end else begin
            op_valid_o <= id_valid_i;
        end
    end

    always_ff @(posedge clk) begin
        op_ctrl_o <= id_ctrl_i;
        op_a_o    <= rs1_val;
        op_b_o    <= id_ctrl_i.use_imm ? id_ctrl_i.imm : rs2_val;
    end

    // producers never offer x0
    assert property (@(posedge clk) disable iff (rst_i)
        !(exe_fwd_i.valid && exe_fwd_i.addr == '0) &&
        !(wb_fwd_i.valid && wb_fwd_i.addr == '0));

endmodule

`default_nettype wire

/* pipeline/execute_stage.sv */
`default_nettype none

module execute_stage (
    input  wire                          clk,
    input  wire                          rst_i,
    input  wire                          op_valid_i,
    input  wire isa_pkg::ctrl_t          op_ctrl_i,
    input  wire core_types_pkg::word_t   op_a_i,
    input  wire core_types_pkg::word_t   op_b_i,
    output isa_pkg::fwd_t                exe_fwd_o,
    output isa_pkg::fwd_t                wb_fwd_o,
    output isa_pkg::retire_t             retire_o
);

    import core_types_pkg::*;
    import isa_pkg::*;

    word_t   alu_res;
    retire_t exe_d;
    retire_t exe_q;
    retire_t ret_q;

    always_comb begin
        case (op_ctrl_i.alu_op)
            ALU_ADD: alu_res = op_a_i + op_b_i;
            ALU_SUB: alu_res = op_a_i - op_b_i;
            ALU_AND: alu_res = op_a_i & op_b_i;
            ALU_OR:  alu_res = op_a_i | op_b_i;
            ALU_XOR: alu_res = op_a_i ^ op_b_i;
            ALU_SLL: alu_res = op_a_i << op_b_i[4:0];
            ALU_SRL: alu_res = op_a_i >> op_b_i[4:0];
            default: alu_res = op_b_i;
        endcase
    end

    assign exe_d = '{
        valid:   op_valid_i,
        wen:     op_ctrl_i.rf_wen,
        illegal: op_ctrl_i.illegal,
        rd:      op_ctrl_i.rd,
        wdata:   alu_res
    };

    // result leaves for operand select in the cycle it is computed
    assign exe_fwd_o = '{valid: exe_d.valid & exe_d.wen, addr: exe_d.rd, wdata: alu_res};

    // execute register is one ahead of retire and feeds the rf write
    assign wb_fwd_o = '{valid: exe_q.valid & exe_q.wen, addr: exe_q.rd, wdata: exe_q.wdata};
    assign retire_o = ret_q;

    always_ff @(posedge clk) begin
        if (rst_i) begin
            exe_q.valid <= 1'b0;
            ret_q.valid <= 1'b0;
        end else begin
            exe_q <= exe_d;
            ret_q <= exe_q;
        end
    end

    assert property (@(posedge clk) disable iff (rst_i)
        retire_o.valid |-> !(retire_o.wen && retire_o.illegal));

endmodule

`default_nettype wire

/* hdl/core_top.sv */
`default_nettype none

module core_top (
    input  wire                        clk,
    input  wire                        rst_i,
    input  wire                        inst_valid_i,
    input  wire core_types_pkg::inst_t inst_i,
    output logic                       credit_o,
    output isa_pkg::retire_t           retire_o
);

    import core_types_pkg::*;
    import isa_pkg::*;

    logic  deq_valid;
    inst_t deq_inst;

    logic  id_valid;
    ctrl_t id_ctrl;

    logic  op_valid;
    ctrl_t op_ctrl;
    word_t op_a;
    word_t op_b;

    fwd_t  exe_fwd;
    fwd_t  wb_fwd;

    inst_queue u_inst_queue (
        .clk          (clk),
        .rst_i        (rst_i),
        .inst_valid_i (inst_valid_i),
        .inst_i       (inst_i),
        .deq_valid_o  (deq_valid),
        .deq_inst_o   (deq_inst),
        .credit_o     (credit_o)
    );

    decode_stage u_decode_stage (
        .clk         (clk),
        .rst_i       (rst_i),
        .deq_valid_i (deq_valid),
        .deq_inst_i  (deq_inst),
        .id_valid_o  (id_valid),
        .id_ctrl_o   (id_ctrl)
    );

    operand_stage u_operand_stage (
        .clk        (clk),
        .rst_i      (rst_i),
        .id_valid_i (id_valid),
        .id_ctrl_i  (id_ctrl),
        .exe_fwd_i  (exe_fwd),
        .wb_fwd_i   (wb_fwd),
        .op_valid_o (op_valid),
        .op_ctrl_o  (op_ctrl),
        .op_a_o     (op_a),
        .op_b_o     (op_b)
    );

    execute_stage u_execute_stage (
        .clk        (clk),
        .rst_i      (rst_i),
        .op_valid_i (op_valid),
        .op_ctrl_i  (op_ctrl),
        .op_a_i     (op_a),
        .op_b_i     (op_b),
        .exe_fwd_o  (exe_fwd),
        .wb_fwd_o   (wb_fwd),
        .retire_o   (retire_o)
    );

endmodule

`default_nettype wire

/* tb/core_tb.sv */
`default_nettype none

module core_tb;

    timeunit 1ns;
    timeprecision 1ps;

    import core_types_pkg::*;
    import isa_pkg::*;

    localparam int RETIRE_TIMEOUT = 50;
    localparam int CREDIT_TIMEOUT = 50;

    typedef struct packed {
        inst_t     inst;
        logic      wen;
        logic      illegal;
        reg_addr_t rd;
        word_t     wdata;
        logic      dense;
    } row_t;

    logic    clk;
    logic    rst_i;
    logic    inst_valid_i;
    inst_t   inst_i;
    logic    credit_o;
    retire_t retire_o;

    row_t        rows[$];
    logic [31:0] lfsr;
    int          credits;
    int          sent;
    int          credit_pulses;

    core_top dut (
        .clk          (clk),
        .rst_i        (rst_i),
        .inst_valid_i (inst_valid_i),
        .inst_i       (inst_i),
        .credit_o     (credit_o),
        .retire_o     (retire_o)
    );

    initial begin
        clk = 1'b0;
        forever #10 clk = ~clk;
    end

    // sees the value credit_o held over the cycle that just ended
    always @(posedge clk) begin
        if (!rst_i && credit_o) begin
            credit_pulses++;
        end
    end

    //////////////////////////////
    // helpers

    // x^32 + x^22 + x^2 + x + 1
    function automatic logic [31:0] lfsr_step(input logic [31:0] s);
        logic fb;
        fb = s[31] ^ s[21] ^ s[1] ^ s[0];
        return {s[30:0], fb};
    endfunction

    function automatic inst_t r_format(input logic [6:0] f7, input logic [2:0] f3,
                                       input reg_addr_t rd, input reg_addr_t rs1,
                                       input reg_addr_t rs2);
        return {f7, rs2, rs1, f3, rd, 7'b0110011};
    endfunction

    function automatic inst_t i_format(input logic [2:0] f3, input reg_addr_t rd,
                                       input reg_addr_t rs1, input logic [11:0] imm);
        return {imm, rs1, f3, rd, 7'b0010011};
    endfunction

    function automatic inst_t u_format(input reg_addr_t rd, input logic [19:0] imm);
        return {imm, rd, 7'b0110111};
    endfunction

    task automatic add_row(input inst_t inst, input logic wen, input logic illegal,
                           input reg_addr_t rd, input word_t wdata, input logic dense);
        rows.push_back(row_t'{inst, wen, illegal, rd, wdata, dense});
    endtask

    task automatic stop_run(input string why);
        $display("Simulation failed");
        $fatal(1, "%s", why);
    endtask

    task automatic check_equal(input string what, input word_t got, input word_t exp);
        if (got !== exp) begin
            $display("ERR %0t: %s expected %h got %h", $time, what, exp, got);
            stop_run("value mismatch");
        end
    endtask

    //////////////////////////////
    // expected results by hand

    task automatic load_table();
        // independent ops, issue gaps allowed
        add_row(i_format(3'b000, 5'd1, 5'd0, 12'h123), 1'b1, 1'b0, 5'd1, 32'h0000_0123, 1'b0);
        add_row(i_format(3'b000, 5'd2, 5'd0, 12'hfff), 1'b1, 1'b0, 5'd2, 32'hffff_ffff, 1'b0);
        add_row(u_format(5'd3, 20'h12345), 1'b1, 1'b0, 5'd3, 32'h1234_5000, 1'b0);
        add_row(i_format(3'b110, 5'd4, 5'd0, 12'h5a5), 1'b1, 1'b0, 5'd4, 32'h0000_05a5, 1'b0);
        add_row(i_format(3'b000, 5'd5, 5'd0, 12'h004), 1'b1, 1'b0, 5'd5, 32'h0000_0004, 1'b0);
        add_row(r_format(7'h00, 3'b000, 5'd6, 5'd1, 5'd4), 1'b1, 1'b0, 5'd6, 32'h0000_06c8, 1'b0);
        add_row(r_format(7'h20, 3'b000, 5'd7, 5'd1, 5'd4), 1'b1, 1'b0, 5'd7, 32'hffff_fb7e, 1'b0);
        add_row(r_format(7'h00, 3'b111, 5'd8, 5'd2, 5'd3), 1'b1, 1'b0, 5'd8, 32'h1234_5000, 1'b0);
        add_row(r_format(7'h00, 3'b110, 5'd9, 5'd1, 5'd3), 1'b1, 1'b0, 5'd9, 32'h1234_5123, 1'b0);
        add_row(r_format(7'h00, 3'b100, 5'd10, 5'd2, 5'd4), 1'b1, 1'b0, 5'd10, 32'hffff_fa5a, 1'b0);
        add_row(r_format(7'h00, 3'b001, 5'd11, 5'd3, 5'd5), 1'b1, 1'b0, 5'd11, 32'h2345_0000, 1'b0);
        // shift amount is 0x123 & 31 = 3
        add_row(r_format(7'h00, 3'b101, 5'd12, 5'd2, 5'd1), 1'b1, 1'b0, 5'd12, 32'h1fff_ffff, 1'b0);
        add_row(i_format(3'b111, 5'd13, 5'd2, 12'h0f0), 1'b1, 1'b0, 5'd13, 32'h0000_00f0, 1'b0);
        add_row(i_format(3'b100, 5'd14, 5'd1, 12'hfff), 1'b1, 1'b0, 5'd14, 32'hffff_fedc, 1'b0);
        add_row(i_format(3'b110, 5'd15, 5'd3, 12'h800), 1'b1, 1'b0, 5'd15, 32'hffff_f800, 1'b0);

        // back to back from here, distance 1 and 2 need the bypasses
        add_row(i_format(3'b000, 5'd20, 5'd0, 12'h00a), 1'b1, 1'b0, 5'd20, 32'h0000_000a, 1'b1);
        add_row(i_format(3'b000, 5'd20, 5'd20, 12'h005), 1'b1, 1'b0, 5'd20, 32'h0000_000f, 1'b1);
        add_row(r_format(7'h00, 3'b000, 5'd21, 5'd20, 5'd20), 1'b1, 1'b0, 5'd21, 32'h1e, 1'b1);
        add_row(r_format(7'h20, 3'b000, 5'd22, 5'd20, 5'd5), 1'b1, 1'b0, 5'd22, 32'h0b, 1'b1);
        add_row(r_format(7'h00, 3'b100, 5'd23, 5'd21, 5'd22), 1'b1, 1'b0, 5'd23, 32'h15, 1'b1);
        // execute copy of x26 must beat the older one
        add_row(i_format(3'b000, 5'd26, 5'd0, 12'h001), 1'b1, 1'b0, 5'd26, 32'h1, 1'b1);
        add_row(i_format(3'b000, 5'd26, 5'd0, 12'h002), 1'b1, 1'b0, 5'd26, 32'h2, 1'b1);
        add_row(r_format(7'h00, 3'b000, 5'd27, 5'd26, 5'd0), 1'b1, 1'b0, 5'd27, 32'h2, 1'b1);

        // x0 target
        add_row(i_format(3'b000, 5'd0, 5'd0, 12'h7ff), 1'b0, 1'b0, 5'd0, 32'h7ff, 1'b1);
        add_row(r_format(7'h00, 3'b000, 5'd28, 5'd0, 5'd1), 1'b1, 1'b0, 5'd28, 32'h123, 1'b1);

        // illegal encodings leave x30 alone
        add_row(i_format(3'b000, 5'd30, 5'd0, 12'h055), 1'b1, 1'b0, 5'd30, 32'h55, 1'b1);
        // lw x30, 0(x1)
        add_row(32'h0000_af03, 1'b0, 1'b1, 5'd30, 32'h0, 1'b1);
        add_row(r_format(7'h01, 3'b000, 5'd30, 5'd1, 5'd1), 1'b0, 1'b1, 5'd30, 32'h0, 1'b1);
        add_row(i_format(3'b000, 5'd31, 5'd30, 12'h000), 1'b1, 1'b0, 5'd31, 32'h55, 1'b1);
    endtask

    //////////////////////////////
    // source and monitor

    task automatic next_slot();
        @(negedge clk);
        inst_valid_i = 1'b0;
        if (credit_o) begin
            credits++;
        end
        if (credits > QUEUE_DEPTH) begin
            $display("%0t: queue returned more credits than were spent", $time);
            stop_run("credit overflow");
        end
    endtask

    task automatic drive_rows();
        int waited;
        for (int i = 0; i < rows.size(); i++) begin
            if (!rows[i].dense) begin
                lfsr = lfsr_step(lfsr);
                if (lfsr[0]) begin
                    next_slot();
                end
            end
            next_slot();
            waited = 0;
            while (credits == 0) begin
                if (waited == CREDIT_TIMEOUT) begin
                    $display("%0t: no credit came back for %0d cycles", $time, waited);
                    stop_run("credit timeout");
                end
                next_slot();
                waited++;
            end
            inst_i       = rows[i].inst;
            inst_valid_i = 1'b1;
            credits--;
            sent++;
        end
        next_slot();
        waited = 0;
        while (credits != QUEUE_DEPTH) begin
            if (waited == CREDIT_TIMEOUT) begin
                $display("%0t: only %0d credits back after the last send", $time, credits);
                stop_run("credit drain timeout");
            end
            next_slot();
            waited++;
        end
    endtask

    task automatic check_retires();
        int waited;
        for (int i = 0; i < rows.size(); i++) begin
            waited = 0;
            @(negedge clk);
            while (!retire_o.valid) begin
                if (waited == RETIRE_TIMEOUT) begin
                    $display("%0t: row %0d did not retire within %0d cycles", $time, i, waited);
                    stop_run("retire timeout");
                end
                @(negedge clk);
                waited++;
            end
            check_equal($sformatf("row %0d wen", i), word_t'(retire_o.wen),
                        word_t'(rows[i].wen));
            check_equal($sformatf("row %0d illegal", i), word_t'(retire_o.illegal),
                        word_t'(rows[i].illegal));
            check_equal($sformatf("row %0d rd", i), word_t'(retire_o.rd), word_t'(rows[i].rd));
            // result of an illegal op means nothing
            if (!rows[i].illegal) begin
                check_equal($sformatf("row %0d wdata", i), retire_o.wdata, rows[i].wdata);
            end
        end
    endtask

    initial begin
        rst_i         = 1'b1;
        inst_valid_i  = 1'b0;
        inst_i        = '0;
        lfsr          = 32'h1c815d95;
        credits       = QUEUE_DEPTH;
        sent          = 0;
        credit_pulses = 0;
        load_table();

        repeat (4) @(negedge clk);
        rst_i = 1'b0;

        @(negedge clk);
        check_equal("credit after reset", word_t'(credit_o), '0);
        check_equal("retire valid after reset", word_t'(retire_o.valid), '0);

        fork
            drive_rows();
            check_retires();
        join

        // nothing extra may retire
        repeat (4) begin
            @(negedge clk);
            check_equal("retire valid after last row", word_t'(retire_o.valid), '0);
        end

        check_equal("credit pulses", word_t'(credit_pulses), word_t'(sent));

        $display("Simulation completed successfully");
        $finish;
    end

endmodule

`default_nettype wire

/* filelist.f */
common/core_types_pkg.sv
common/isa_pkg.sv
hdl/inst_queue.sv
pipeline/decode_stage.sv
pipeline/operand_stage.sv
pipeline/execute_stage.sv
hdl/core_top.sv
tb/core_tb.sv

/* run.sh */
#!/bin/sh
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert --timescale 1ns/1ps \
    -f filelist.f --top-module core_tb -o core_tb_sim

status=0
./obj_dir/core_tb_sim > sim.log 2>&1 || status=$?
cat sim.log
echo "simulator exit status: $status"

grep -qx "Simulation completed successfully" sim.log || {
    echo "run.sh: pass line not found in sim.log"
    exit 1
}
